//--- src/jumpUnit_config.svh
`ifndef JUMPUNIT_CONFIG_SVH
`define JUMPUNIT_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// datapath sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// word width of registers, PC and instruction bus
`define JU_DATA_WIDTH 16

// register file depth
`define JU_REG_COUNT 8

// register written by jump-and-link
`define JU_LINK_REG 7

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// program counter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// byte addressed, one instruction is two bytes
`define JU_PC_STEP 2

`define JU_RESET_PC 0

`endif

//--- src/jumpPkg.sv
`include "jumpUnit_config.svh"

package jumpPkg;

	localparam int REG_ADDR_W = $clog2(`JU_REG_COUNT);

	typedef enum logic [1:0] {FETCH, DECODE, EXECUTE, COMMIT} phaseT;

	// only the jump group is handled in this slice
	typedef enum logic [1:0] {GENERAL, LOADSTORE, JUMP, ALU} groupT;

	typedef enum logic [1:0] {CC_Z, CC_C, CC_S, CC_P} ccSelT;

	typedef enum logic [1:0] {absReg, relReg, relShort, reserved} jumpModeT;

	typedef struct packed {
		groupT group;
		logic ccApply;
		logic ccInvert;
		ccSelT ccSel;
		jumpModeT mode;
		logic link;
		logic [REG_ADDR_W-1:0] regB;
		logic [3:0] shortOffset;
	} instrT;

	typedef struct packed {
		logic zero;
		logic carry;
		logic sign;
		logic parity;
	} flagsT;

	typedef enum logic {BASE_PC, BASE_REGB} pcBaseT;

	typedef enum logic [1:0] {OFF_ZERO, OFF_STEP, OFF_REGB, OFF_SHORT} pcOffsetT;

	typedef struct packed {
		pcBaseT pcBase;
		pcOffsetT pcOffset;
		logic [REG_ADDR_W-1:0] regBAddr;
		logic [3:0] shortOffset;
		logic linkWrite;
		logic taken;
	} ctrlWordT;

	typedef struct packed {
		logic valid;
		logic [REG_ADDR_W-1:0] addr;
		logic [`JU_DATA_WIDTH-1:0] data;
	} regLoadT;

	typedef struct packed {
		logic valid;
		logic [`JU_DATA_WIDTH-1:0] pc;
		logic [`JU_DATA_WIDTH-1:0] nextPc;
		logic taken;
		logic linked;
	} retireT;

endpackage

//--- src/instructionPhaseDecoder.sv
`include "jumpUnit_config.svh"

module instructionPhaseDecoder
	import jumpPkg::*;
(
	input  logic                      CLK,
	input  logic                      rstN,
	input  logic [`JU_DATA_WIDTH-1:0] din,
	output phaseT                     phase,
	output instrT                     instruction
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// phase ring
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	phaseT phaseQ;

	// COMMIT wraps back to FETCH on the 2-bit overflow
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			phaseQ <= FETCH;
		end else begin
			phaseQ <= phaseT'(phaseQ + 2'd1);
		end
	end

	assign phase = phaseQ;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// instruction latch
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	instrT instrQ;

	// memory presents din in the FETCH cycle, held for the other three
	always_ff @(posedge CLK) begin
		if (phaseQ == FETCH) begin
			instrQ <= instrT'(din);
		end
	end

	assign instruction = instrQ;

endmodule

//--- src/jumpGroupDecoder.sv
module jumpGroupDecoder
	import jumpPkg::*;
(
	input  logic     CLK,
	input  logic     rstN,
	input  phaseT    phase,
	input  instrT    instruction,
	input  flagsT    flags,
	output ctrlWordT ctrl
);

	logic ccFlag;
	logic ccPass;
	logic isJump;
	logic taken;
	ctrlWordT ctrlNext;
	ctrlWordT ctrlQ;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// condition evaluation
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		case (instruction.ccSel)
			CC_Z:    ccFlag = flags.zero;
			CC_C:    ccFlag = flags.carry;
			CC_S:    ccFlag = flags.sign;
			default: ccFlag = flags.parity;
		endcase
	end

	// unconditional when ccApply is clear
	assign ccPass = !instruction.ccApply || (ccFlag ^ instruction.ccInvert);

	assign isJump = (instruction.group == JUMP) && (instruction.mode != reserved);
	assign taken  = isJump && ccPass;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// control word
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		ctrlNext.regBAddr    = instruction.regB;
		ctrlNext.shortOffset = instruction.shortOffset;
		ctrlNext.linkWrite   = instruction.link && taken;
		ctrlNext.taken       = taken;
		// straight-line default, PC + step
		ctrlNext.pcBase      = BASE_PC;
		ctrlNext.pcOffset    = OFF_STEP;
		if (taken) begin
			case (instruction.mode)
				absReg: begin
					ctrlNext.pcBase   = BASE_REGB;
					ctrlNext.pcOffset = OFF_ZERO;
				end
				relReg: begin
					ctrlNext.pcOffset = OFF_REGB;
				end
				default: begin
					ctrlNext.pcOffset = OFF_SHORT;
				end
			endcase
		end
	end

	// flags are sampled once, in DECODE
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			ctrlQ <= '0;
		end else if (phase == DECODE) begin
			ctrlQ <= ctrlNext;
		end
	end

	assign ctrl = ctrlQ;

endmodule

//--- src/registerFile.sv
`include "jumpUnit_config.svh"

module registerFile
	import jumpPkg::*;
(
	input  logic                      CLK,
	input  logic                      rstN,
	input  logic [REG_ADDR_W-1:0]     readAddr,
	output logic [`JU_DATA_WIDTH-1:0] readData,
	input  logic                      linkWrite,
	input  logic [`JU_DATA_WIDTH-1:0] linkData,
	input  regLoadT                   load
);

	logic [`JU_DATA_WIDTH-1:0] regs [`JU_REG_COUNT];

	// link write comes last so it overrides a load to the same register
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			for (int i = 0; i < `JU_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (load.valid) begin
				regs[load.addr] <= load.data;
			end
			if (linkWrite) begin
				regs[`JU_LINK_REG] <= linkData;
			end
		end
	end

	assign readData = regs[readAddr];

endmodule

//--- src/programCounter.sv
`include "jumpUnit_config.svh"

module programCounter
	import jumpPkg::*;
(
	input  logic                      CLK,
	input  logic                      rstN,
	input  phaseT                     phase,
	input  ctrlWordT                  ctrl,
	input  logic [`JU_DATA_WIDTH-1:0] regBData,
	output logic [`JU_DATA_WIDTH-1:0] pc,
	output logic [`JU_DATA_WIDTH-1:0] linkData,
	output retireT                    retire
);

	logic [`JU_DATA_WIDTH-1:0] pcQ;
	logic [`JU_DATA_WIDTH-1:0] base;
	logic [`JU_DATA_WIDTH-1:0] offset;
	logic [`JU_DATA_WIDTH-1:0] shortExt;
	logic [`JU_DATA_WIDTH-1:0] nextPc;
	retireT retireQ;

	// 4-bit field, sign extended, in instruction units
	assign shortExt = {{(`JU_DATA_WIDTH-5){ctrl.shortOffset[3]}}, ctrl.shortOffset, 1'b0};

	assign base = (ctrl.pcBase == BASE_REGB) ? regBData : pcQ;

	always_comb begin
		case (ctrl.pcOffset)
			OFF_ZERO: offset = '0;
			OFF_STEP: offset = `JU_DATA_WIDTH'(`JU_PC_STEP);
			OFF_REGB: offset = regBData;
			default:  offset = shortExt;
		endcase
	end

	assign nextPc   = base + offset;
	assign linkData = pcQ + `JU_DATA_WIDTH'(`JU_PC_STEP);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// commit
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			pcQ     <= `JU_DATA_WIDTH'(`JU_RESET_PC);
			retireQ <= '0;
		end else if (phase == COMMIT) begin
			pcQ            <= nextPc;
			retireQ.valid  <= 1'b1;
			retireQ.pc     <= pcQ;
			retireQ.nextPc <= nextPc;
			retireQ.taken  <= ctrl.taken;
			retireQ.linked <= ctrl.linkWrite;
		end else begin
			// one-cycle strobe during the following FETCH
			retireQ.valid <= 1'b0;
		end
	end

	assign pc     = pcQ;
	assign retire = retireQ;

endmodule

//--- src/jumpUnit.sv
`include "jumpUnit_config.svh"

module jumpUnit
	import jumpPkg::*;
(
	input  logic                      CLK,
	input  logic                      rstN,
	input  logic [`JU_DATA_WIDTH-1:0] din,
	input  flagsT                     flags,
	input  regLoadT                   load,
	output logic [`JU_DATA_WIDTH-1:0] instrAddr,
	output retireT                    retire
);

	phaseT phase;
	instrT instruction;
	ctrlWordT ctrl;
	logic [`JU_DATA_WIDTH-1:0] regBData;
	logic [`JU_DATA_WIDTH-1:0] linkData;
	logic linkWrite;

	instructionPhaseDecoder phaseDec (
		.CLK(CLK),
		.rstN(rstN),
		.din(din),
		.phase(phase),
		.instruction(instruction)
	);

	jumpGroupDecoder jumpDec (
		.CLK(CLK),
		.rstN(rstN),
		.phase(phase),
		.instruction(instruction),
		.flags(flags),
		.ctrl(ctrl)
	);

	// link register is only written as the PC commits
	assign linkWrite = ctrl.linkWrite && (phase == COMMIT);

	registerFile regFile (
		.CLK(CLK),
		.rstN(rstN),
		.readAddr(ctrl.regBAddr),
		.readData(regBData),
		.linkWrite(linkWrite),
		.linkData(linkData),
		.load(load)
	);

	programCounter pcUnit (
		.CLK(CLK),
		.rstN(rstN),
		.phase(phase),
		.ctrl(ctrl),
		.regBData(regBData),
		.pc(instrAddr),
		.linkData(linkData),
		.retire(retire)
	);

endmodule

//--- bench/clockGen.sv
module clockGen #(
	parameter int PERIOD       = 10,
	parameter int RESET_CYCLES = 3
) (
	output logic CLK,
	output logic rstN
);

	initial begin
		CLK = 1'b0;
		forever #(PERIOD / 2) CLK = ~CLK;
	end

	// reset released on a rising edge, like any other stimulus
	initial begin
		rstN = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		rstN <= 1'b1;
	end

endmodule

//--- bench/jumpUnit_sva.sv
`include "jumpUnit_config.svh"

module jumpUnitSva
	import jumpPkg::*;
(
	input logic                      CLK,
	input logic                      rstN,
	input logic                      linkWrite,
	input logic [`JU_DATA_WIDTH-1:0] instrAddr,
	input retireT                    retire
);

	// failed assertion count, read at the end of the run
	int failures = 0;

	// one strobe, three quiet cycles, then the next strobe
	retirePeriod: assert property (@(posedge CLK) disable iff (!rstN)
		retire.valid |=> !retire.valid ##1 !retire.valid ##1 !retire.valid ##1 retire.valid)
	else begin
		$error("retire strobe is not exactly once every 4 cycles");
		failures++;
	end

	// the fetch address moves only as an instruction retires
	pcMovesOnRetire: assert property (@(posedge CLK) disable iff (!rstN)
		$changed(instrAddr) |-> retire.valid)
	else begin
		$error("instrAddr changed without a retire strobe");
		failures++;
	end

	// a link write lands on the commit edge, so the retire right after reports it
	linkInCommit: assert property (@(posedge CLK) disable iff (!rstN)
		linkWrite |=> retire.valid && retire.linked)
	else begin
		$error("link register written outside the commit of a linked jump");
		failures++;
	end

endmodule

bind jumpUnit jumpUnitSva assertChecks (
	.CLK(CLK),
	.rstN(rstN),
	.linkWrite(linkWrite),
	.instrAddr(instrAddr),
	.retire(retire)
);

//--- bench/jumpUnitTb.sv
`include "jumpUnit_config.svh"

module jumpUnitTb
	import jumpPkg::*;
();

	// reset 1, unconditional 8, conditions 32, link 4, straight-line 4
	localparam int DIRECTED_INSTR = 49;
	localparam int RANDOM_INSTR = 200;
	localparam int RUN_LIMIT = (DIRECTED_INSTR + RANDOM_INSTR) * 40 + 200;
	localparam logic [`JU_DATA_WIDTH-1:0] PC_STEP = `JU_PC_STEP;

	logic CLK;
	logic rstN;
	logic [`JU_DATA_WIDTH-1:0] din;
	flagsT flags;
	regLoadT load;
	logic [`JU_DATA_WIDTH-1:0] instrAddr;
	retireT retire;

	logic [`JU_DATA_WIDTH-1:0] modelPc;
	logic [`JU_DATA_WIDTH-1:0] regModel [`JU_REG_COUNT];
	retireT expQ [$];
	string nameQ [$];
	int issuedCount = 0;
	int retiredCount = 0;
	int cycleCount = 0;
	int checkCount = 0;
	int errorCount = 0;
	integer seed = 32'h1408_9367;

	clockGen clocks (.CLK(CLK), .rstN(rstN));

	jumpUnit dut (
		.CLK(CLK),
		.rstN(rstN),
		.din(din),
		.flags(flags),
		.load(load),
		.instrAddr(instrAddr),
		.retire(retire)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic instrT makeInstr(input groupT group, input logic apply,
			input logic invert, input ccSelT sel, input jumpModeT mode, input logic link,
			input logic [REG_ADDR_W-1:0] regB, input logic [3:0] offset);
		return instrT'({group, apply, invert, sel, mode, link, regB, offset});
	endfunction

	function automatic retireT predictRetire(input instrT ins, input flagsT f,
			input logic [`JU_DATA_WIDTH-1:0] pc, input logic [`JU_DATA_WIDTH-1:0] regB);
		retireT r;
		logic flag;
		logic cond;
		logic [`JU_DATA_WIDTH-1:0] shortBytes;
		case (ins.ccSel)
			CC_Z:    flag = f.zero;
			CC_C:    flag = f.carry;
			CC_S:    flag = f.sign;
			default: flag = f.parity;
		endcase
		cond = ins.ccApply ? (flag != ins.ccInvert) : 1'b1;
		// byte offset, two per instruction
		shortBytes = {{(`JU_DATA_WIDTH-4){ins.shortOffset[3]}}, ins.shortOffset} << 1;
		r = '0;
		r.valid = 1'b1;
		r.pc = pc;
		r.taken = (ins.group == JUMP) && (ins.mode != reserved) && cond;
		r.linked = ins.link && r.taken;
		if (!r.taken) begin
			r.nextPc = pc + PC_STEP;
		end else if (ins.mode == absReg) begin
			r.nextPc = regB;
		end else if (ins.mode == relReg) begin
			r.nextPc = pc + regB;
		end else begin
			r.nextPc = pc + shortBytes;
		end
		return r;
	endfunction

	task automatic checkValue(input string test, input string field,
			input logic [31:0] expected, input logic [31:0] actual);
		checkCount++;
		if (expected !== actual) begin
			errorCount++;
			$display("Fail %s %s: expected %h, actual %h", test, field, expected, actual);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// called on the edge that opens FETCH, returns on the next one
	task automatic issueInstr(input string name, input instrT ins, input flagsT f,
			input regLoadT ld);
		retireT expected;
		din <= ins;
		flags <= f;
		load <= ld;
		if (ld.valid) begin
			regModel[ld.addr] = ld.data;
		end
		expected = predictRetire(ins, f, modelPc, regModel[ins.regB]);
		expQ.push_back(expected);
		nameQ.push_back(name);
		issuedCount++;
		if (expected.linked) begin
			regModel[`JU_LINK_REG] = modelPc + PC_STEP;
		end
		modelPc = expected.nextPc;
		@(posedge CLK);
		load.valid <= 1'b0;
		repeat (3) @(posedge CLK);
	endtask

	task automatic preloadReg(input logic [REG_ADDR_W-1:0] addr,
			input logic [`JU_DATA_WIDTH-1:0] data);
		regLoadT ld;
		ld.valid = 1'b1;
		ld.addr = addr;
		ld.data = data;
		issueInstr($sformatf("preload r%0d", addr),
			makeInstr(ALU, 1'b0, 1'b0, CC_Z, absReg, 1'b0, '0, 4'h0), '0, ld);
	endtask

	initial begin
		instrT ins;
		flagsT f;
		regLoadT ld;
		logic [31:0] rnd;
		logic [3:0] mask;
		din = '0;
		flags = '0;
		load = '0;
		modelPc = `JU_DATA_WIDTH'(`JU_RESET_PC);
		for (int r = 0; r < `JU_REG_COUNT; r++) begin
			regModel[r] = '0;
		end
		@(posedge rstN);

		issueInstr("reset first", makeInstr(GENERAL, 1'b0, 1'b0, CC_Z, absReg, 1'b0, '0, 4'h0),
			'0, '0);

		preloadReg(3'd1, 16'h0100);
		preloadReg(3'd2, 16'h0040);
		preloadReg(3'd3, 16'hFFF0);
		issueInstr("abs jump r1", makeInstr(JUMP, 0, 0, CC_Z, absReg, 0, 3'd1, 4'h0), '0, '0);
		issueInstr("rel jump r2", makeInstr(JUMP, 0, 0, CC_Z, relReg, 0, 3'd2, 4'h0), '0, '0);
		issueInstr("rel jump r3", makeInstr(JUMP, 0, 0, CC_Z, relReg, 0, 3'd3, 4'h0), '0, '0);
		issueInstr("short fwd", makeInstr(JUMP, 0, 0, CC_Z, relShort, 0, 3'd0, 4'h5), '0, '0);
		issueInstr("short back", makeInstr(JUMP, 0, 0, CC_Z, relShort, 0, 3'd0, 4'hD), '0, '0);

		// selected flag set to val, the other three to its inverse
		for (int sel = 0; sel < 4; sel++) begin
			for (int apply = 0; apply < 2; apply++) begin
				for (int invert = 0; invert < 2; invert++) begin
					for (int val = 0; val < 2; val++) begin
						mask = 4'b1000 >> sel;
						f = flagsT'(val != 0 ? mask : ~mask);
						ins = makeInstr(JUMP, apply[0], invert[0], ccSelT'(sel[1:0]), relShort,
							1'b0, 3'd0, 4'h2);
						issueInstr($sformatf("cond sel %0d apply %0d invert %0d flag %0d",
							sel, apply, invert, val), ins, f, '0);
					end
				end
			end
		end

		issueInstr("link taken", makeInstr(JUMP, 0, 0, CC_Z, relShort, 1, 3'd0, 4'h3), '0, '0);
		issueInstr("return r7", makeInstr(JUMP, 0, 0, CC_Z, absReg, 0, 3'd7, 4'h0), '0, '0);
		issueInstr("link not taken", makeInstr(JUMP, 1, 0, CC_Z, relShort, 1, 3'd0, 4'h3),
			'0, '0);
		issueInstr("return r7 again", makeInstr(JUMP, 0, 0, CC_Z, absReg, 0, 3'd7, 4'h0),
			'0, '0);

		// jump-like fields with link set, none of them may jump
		issueInstr("group general", makeInstr(GENERAL, 0, 0, CC_Z, absReg, 1, 3'd7, 4'h0),
			'0, '0);
		issueInstr("group loadstore", makeInstr(LOADSTORE, 0, 0, CC_Z, relReg, 1, 3'd1, 4'h0),
			'0, '0);
		issueInstr("group alu", makeInstr(ALU, 0, 0, CC_Z, relShort, 1, 3'd0, 4'h4), '0, '0);
		issueInstr("reserved mode", makeInstr(JUMP, 0, 0, CC_Z, reserved, 1, 3'd1, 4'h4),
			'0, '0);

		for (int i = 0; i < RANDOM_INSTR; i++) begin
			rnd = $random(seed);
			ins = instrT'(rnd[15:0]);
			ins.group = JUMP;
			f = flagsT'(rnd[19:16]);
			ld = '0;
			if (i % 8 == 0) begin
				rnd = $random(seed);
				ld.valid = 1'b1;
				ld.addr = rnd[16 +: REG_ADDR_W];
				ld.data = rnd[15:0];
			end
			issueInstr($sformatf("random %0d", i), ins, f, ld);
		end

		wait (retiredCount == issuedCount);
		@(posedge CLK);
		$display("checks %0d, mismatches %0d, assertion failures %0d",
			checkCount, errorCount, dut.assertChecks.failures);
		if (errorCount == 0 && dut.assertChecks.failures == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// checking
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// cycleCount counts edges since reset release, retire n is due at 4 * (n + 1)
	always @(posedge CLK) begin : compareRetire
		retireT expected;
		string name;
		if (!rstN) begin
			cycleCount = 0;
		end else begin
			if (retire.valid) begin
				if (expQ.size() == 0) begin
					errorCount++;
					$display("retire record at pc %h with no instruction outstanding", retire.pc);
				end else begin
					expected = expQ.pop_front();
					name = nameQ.pop_front();
					checkValue(name, "cycle", 32'(4 * (retiredCount + 1)), 32'(cycleCount));
					checkValue(name, "pc", 32'(expected.pc), 32'(retire.pc));
					checkValue(name, "nextPc", 32'(expected.nextPc), 32'(retire.nextPc));
					checkValue(name, "taken", 32'(expected.taken), 32'(retire.taken));
					checkValue(name, "linked", 32'(expected.linked), 32'(retire.linked));
					// fetch of the following instruction is already under way
					checkValue(name, "instrAddr", 32'(expected.nextPc), 32'(instrAddr));
					retiredCount++;
				end
			end
			cycleCount++;
		end
	end

	initial begin : runLimit
		#(RUN_LIMIT);
		$display("timeout: only %0d of %0d instructions retired", retiredCount,
			DIRECTED_INSTR + RANDOM_INSTR);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+src
src/jumpPkg.sv
src/instructionPhaseDecoder.sv
src/jumpGroupDecoder.sv
src/registerFile.sv
src/programCounter.sv
src/jumpUnit.sv
bench/clockGen.sv
bench/jumpUnit_sva.sv
bench/jumpUnitTb.sv

//--- Bender.yml
package:
  name: jump_unit

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/jumpPkg.sv
      - src/instructionPhaseDecoder.sv
      - src/jumpGroupDecoder.sv
      - src/registerFile.sv
      - src/programCounter.sv
      - src/jumpUnit.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/clockGen.sv
      - bench/jumpUnit_sva.sv
      - bench/jumpUnitTb.sv
